// ==== Makefile ====
TOP  = tb_cnv_row
SRCS = $(shell grep -v '^+' list.f)

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

obj_dir/V$(TOP): list.f $(SRCS) verilog/cnv_defs.svh
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== list.f ====
+incdir+verilog
verilog/cnv_pkg.sv
verilog/mac_if.sv
verilog/sparse_mac.sv
verilog/psum_row_acc.sv
verilog/cnv_row.sv
verif/tb_cnv_row.sv

// ==== verif/tb_cnv_row.sv ====
/*
 * Convolution row unit testbench
 * Directed tests checked against a masked dot product model of both lanes
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnv_defs.svh"

module tb_cnv_row;

    // 1 + 1 + 2 + 7 + 2 + 20 blocks over all tests
    localparam int            TOTAL_BLOCKS   = 33;
    localparam int            TIMEOUT_CYCLES = 40 * TOTAL_BLOCKS + 100;
    localparam cnv_pkg::col_t LAST_COL       = cnv_pkg::col_t'(`CNV_LENROW - 1);

    // ========================================================================
    // DUT signals
    // ========================================================================
    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    cnv_pkg::block_t act;
    cnv_pkg::flag_t  act_flag;
    cnv_pkg::block_t wei0;
    cnv_pkg::flag_t  wei0_flag;
    cnv_pkg::block_t wei1;
    cnv_pkg::flag_t  wei1_flag;
    cnv_pkg::psum_t  psum_in;
    logic            row_last;
    logic            out_valid;
    logic            out_ready;
    cnv_pkg::psum_t  out_psum;
    cnv_pkg::col_t   out_col;
    logic            out_row_end;

    integer          seed;
    int              cycle_cnt;
    // Column the next result should report
    cnv_pkg::col_t   exp_col;

    cnv_row cnv_row_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .act         (act),
        .act_flag    (act_flag),
        .wei0        (wei0),
        .wei0_flag   (wei0_flag),
        .wei1        (wei1),
        .wei1_flag   (wei1_flag),
        .psum_in     (psum_in),
        .row_last    (row_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_psum    (out_psum),
        .out_col     (out_col),
        .out_row_end (out_row_end)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, DUT never completed a handshake", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_psum(input string name, input cnv_pkg::psum_t got,
                              input cnv_pkg::psum_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "partial sum mismatch");
        end
    endtask

    task automatic check_col(input string name, input cnv_pkg::col_t got,
                             input cnv_pkg::col_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "column mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "control bit mismatch");
        end
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    // Sum of products where both flags are set
    function automatic int masked_dot(input cnv_pkg::block_t a, input cnv_pkg::flag_t af,
                                      input cnv_pkg::block_t w, input cnv_pkg::flag_t wf);
        int acc;
        acc = 0;
        for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
            if (af[i] && wf[i]) begin
                acc += int'(a[i]) * int'(w[i]);
            end
        end
        return acc;
    endfunction

    // ========================================================================
    // Block driver and result checker
    // ========================================================================
    // All tasks enter and leave 5 ns after a rising edge
    task automatic run_block(input cnv_pkg::block_t a, input cnv_pkg::flag_t af,
                             input cnv_pkg::block_t w0, input cnv_pkg::flag_t w0f,
                             input cnv_pkg::block_t w1, input cnv_pkg::flag_t w1f,
                             input cnv_pkg::psum_t p, input logic last, input int stall);
        cnv_pkg::psum_t exp_psum;
        cnv_pkg::psum_t held;
        exp_psum = cnv_pkg::psum_t'(masked_dot(a, af, w0, w0f) + masked_dot(a, af, w1, w1f)
                                    + int'(p));
        act       = a;
        act_flag  = af;
        wei0      = w0;
        wei0_flag = w0f;
        wei1      = w1;
        wei1_flag = w1f;
        psum_in   = p;
        row_last  = last;
        in_valid  = 1'b1;
        while (!in_ready) begin
            @(posedge clk);
            #5;
        end
        // Transfer edge
        @(posedge clk);
        #5;
        in_valid = 1'b0;
        // Lanes latch operands on the start edge
        @(posedge clk);
        #5;
        while (!out_valid) begin
            @(posedge clk);
            #5;
        end
        check_bit("in_ready", in_ready, 1'b0);
        held = out_psum;
        // Stall with out_ready low
        for (int k = 0; k < stall; k++) begin
            @(posedge clk);
            #5;
            check_bit("out_valid", out_valid, 1'b1);
            check_psum("out_psum", out_psum, held);
            check_bit("in_ready", in_ready, 1'b0);
        end
        check_psum("out_psum", out_psum, exp_psum);
        check_col("out_col", out_col, exp_col);
        check_bit("out_row_end", out_row_end, last);
        out_ready = 1'b1;
        @(posedge clk);
        #5;
        out_ready = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        // Countdown, reload at row end or column 0
        if (last || (exp_col == '0)) begin
            exp_col = LAST_COL;
        end else begin
            exp_col = exp_col - 1'b1;
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic verify_reset_state();
        cnv_pkg::block_t a;
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
        for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
            a[i] = cnv_pkg::data_t'(i + 1);
        end
        // First result lands on the last column
        run_block(a, 8'hff, a, 8'h0f, a, 8'hf0, 24'sd10, 1'b0, 0);
    endtask

    task automatic dense_block();
        cnv_pkg::block_t a;
        cnv_pkg::block_t w0;
        cnv_pkg::block_t w1;
        // Mixed signs so negative products appear
        for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
            a[i]  = cnv_pkg::data_t'(i * 17 - 60);
            w0[i] = cnv_pkg::data_t'(25 - i * 9);
            w1[i] = cnv_pkg::data_t'(-(i + 1) * 11);
        end
        run_block(a, '1, w0, '1, w1, '1, -24'sd500, 1'b0, 0);
    endtask

    task automatic sparse_masks();
        cnv_pkg::block_t a;
        cnv_pkg::block_t w;
        for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
            a[i] = cnv_pkg::data_t'(-7 * i - 3);
            w[i] = cnv_pkg::data_t'(13 * i + 5);
        end
        // Disjoint masks, only psum_in survives
        run_block(a, 8'h0f, w, 8'hf0, w, 8'h30, -24'sd1234, 1'b0, 0);
        // One match at position 2 on lane 0, row closed here
        run_block(a, 8'b0010_0110, w, 8'b0000_0100, w, 8'b1001_0000, 24'sd777, 1'b1, 0);
    endtask

    task automatic column_walk();
        cnv_pkg::block_t a;
        cnv_pkg::block_t w;
        for (int k = 0; k < `CNV_LENROW + 1; k++) begin
            for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
                a[i] = cnv_pkg::data_t'(k * 8 + i - 20);
                w[i] = cnv_pkg::data_t'(3 - i - k);
            end
            // Row ends on the final column
            run_block(a, 8'h5a, w, 8'h3c, w, 8'hc3, cnv_pkg::psum_t'(k * 100),
                      k == `CNV_LENROW - 1, 0);
        end
    endtask

    task automatic back_pressure();
        cnv_pkg::block_t a;
        for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
            a[i] = cnv_pkg::data_t'(100 - 29 * i);
        end
        run_block(a, 8'hff, a, 8'haa, a, 8'h55, 24'sd42, 1'b0, 5);
        // Next block gets in straight after release
        run_block(a, 8'h81, a, 8'hff, a, 8'h01, -24'sd42, 1'b0, 0);
    endtask

    task automatic random_blocks();
        cnv_pkg::block_t a;
        cnv_pkg::block_t w0;
        cnv_pkg::block_t w1;
        cnv_pkg::flag_t  af;
        cnv_pkg::flag_t  w0f;
        cnv_pkg::flag_t  w1f;
        cnv_pkg::psum_t  p;
        logic            last;
        int              stall;
        for (int n = 0; n < 20; n++) begin
            for (int i = 0; i < `CNV_BLOCK_DEPTH; i++) begin
                a[i]  = cnv_pkg::data_t'($random(seed));
                w0[i] = cnv_pkg::data_t'($random(seed));
                w1[i] = cnv_pkg::data_t'($random(seed));
            end
            af    = cnv_pkg::flag_t'($random(seed));
            w0f   = cnv_pkg::flag_t'($random(seed));
            w1f   = cnv_pkg::flag_t'($random(seed));
            p     = cnv_pkg::psum_t'($random(seed));
            // Occasional early row end
            last  = (($random(seed) & 7) == 0);
            stall = $random(seed) & 3;
            run_block(a, af, w0, w0f, w1, w1f, p, last, stall);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        act       = '0;
        act_flag  = '0;
        wei0      = '0;
        wei0_flag = '0;
        wei1      = '0;
        wei1_flag = '0;
        psum_in   = '0;
        row_last  = 1'b0;
        out_ready = 1'b0;
        seed      = 32'h233c_90fd;
        cycle_cnt = 0;
        exp_col   = LAST_COL;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        verify_reset_state();
        dense_block();
        sparse_masks();
        column_walk();
        back_pressure();
        random_blocks();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cnv_defs.svh ====
/*
 * Convolution row unit sizes
 * Data, block, row and accumulator widths shared by the package and RTL
 */
`ifndef CNV_DEFS_SVH
`define CNV_DEFS_SVH

// ========================================================================
// Data and block geometry
// ========================================================================
// One activation or weight word
`define CNV_DATA_W      8
// Positions per block, one flag bit each
`define CNV_BLOCK_DEPTH 8

// ========================================================================
// Row geometry and sum widths
// ========================================================================
// Output columns per row
`define CNV_LENROW      6
`define CNV_COL_W       3
// Full product plus guard bits for the block sum
`define CNV_MAC_W       (2 * `CNV_DATA_W + 4)
// Lane sums plus incoming partial sum
`define CNV_PSUM_W      (`CNV_MAC_W + 4)
// Hit counter, counts 0 up to a full block
`define CNV_HIT_W       ($clog2(`CNV_BLOCK_DEPTH + 1))

`endif

// ==== verilog/cnv_pkg.sv ====
/*
 * Convolution row package
 * Data, block, sum, column and FSM state types for the row unit
 */
`default_nettype none

`include "cnv_defs.svh"

package cnv_pkg;

    // ========================================================================
    // Data types
    // ========================================================================
    // Signed activation or weight
    typedef logic signed [`CNV_DATA_W-1:0] data_t;

    // Whole block, element 0 in the low bits
    typedef data_t [`CNV_BLOCK_DEPTH-1:0] block_t;

    // Set bit marks a nonzero entry
    typedef logic [`CNV_BLOCK_DEPTH-1:0] flag_t;

    // Sum of one lane over one block
    typedef logic signed [`CNV_MAC_W-1:0] mac_t;

    // Partial sum of one output column
    typedef logic signed [`CNV_PSUM_W-1:0] psum_t;

    // Output column address
    typedef logic [`CNV_COL_W-1:0] col_t;

    // ========================================================================
    // FSM states
    // ========================================================================
    // Lane FSM
    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_RUN,
        MAC_DONE
    } mac_state_e;

    // Accumulator FSM
    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_WAIT_MAC,
        ACC_OUT
    } acc_state_e;

endpackage

`default_nettype wire

// ==== verilog/cnv_row.sv ====
/*
 * Convolution row unit, top level
 * Two parallel sparse MAC lanes, one per weight row, feeding a partial sum
 * accumulator that streams one output column per block
 */
`timescale 1ns/1ps
`default_nettype none

module cnv_row (
    input  logic            clk,
    input  logic            rst_n,
    // Block input
    input  logic            in_valid,
    output logic            in_ready,
    input  cnv_pkg::block_t act,
    input  cnv_pkg::flag_t  act_flag,
    input  cnv_pkg::block_t wei0,
    input  cnv_pkg::flag_t  wei0_flag,
    input  cnv_pkg::block_t wei1,
    input  cnv_pkg::flag_t  wei1_flag,
    input  cnv_pkg::psum_t  psum_in,
    input  logic            row_last,
    // Result output
    output logic            out_valid,
    input  logic            out_ready,
    output cnv_pkg::psum_t  out_psum,
    output cnv_pkg::col_t   out_col,
    output logic            out_row_end
);

    // ========================================================================
    // Lane links
    // ========================================================================
    mac_if lane0_if ();
    mac_if lane1_if ();

    // ========================================================================
    // Accumulator
    // ========================================================================
    psum_row_acc u_acc (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .psum_in     (psum_in),
        .row_last    (row_last),
        .lane0       (lane0_if.acc),
        .lane1       (lane1_if.acc),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_psum    (out_psum),
        .out_col     (out_col),
        .out_row_end (out_row_end)
    );

    // ========================================================================
    // MAC lanes
    // ========================================================================
    // Both lanes share the activation block
    // Weight row 0
    sparse_mac u_mac0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .act      (act),
        .act_flag (act_flag),
        .wei      (wei0),
        .wei_flag (wei0_flag),
        .port     (lane0_if.mac)
    );

    // Weight row 1
    sparse_mac u_mac1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .act      (act),
        .act_flag (act_flag),
        .wei      (wei1),
        .wei_flag (wei1_flag),
        .port     (lane1_if.mac)
    );

endmodule

`default_nettype wire

// ==== verilog/mac_if.sv ====
/*
 * Accumulator to MAC lane link
 * Start strobe toward the lane, valid/ready result with sum and hit count back
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnv_defs.svh"

interface mac_if;

    // Launch strobe, only while the lane is idle
    logic                  start;

    // Result handshake
    logic                  res_valid;
    logic                  res_ready;

    // Result payload, held from res_valid until taken
    cnv_pkg::mac_t         sum;
    logic [`CNV_HIT_W-1:0] hits;

    // Accumulator side
    modport acc (
        output start,
        output res_ready,
        input  res_valid,
        input  sum,
        input  hits
    );

    // Lane side
    modport mac (
        input  start,
        input  res_ready,
        output res_valid,
        output sum,
        output hits
    );

endinterface

`default_nettype wire

// ==== verilog/psum_row_acc.sv ====
/*
 * Partial sum row accumulator
 * Accepts one block at a time, launches both MAC lanes, adds their sums to
 * the incoming partial sum and walks the column address down the row
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnv_defs.svh"

module psum_row_acc (
    input  logic           clk,
    input  logic           rst_n,
    // Block input
    input  logic           in_valid,
    output logic           in_ready,
    input  cnv_pkg::psum_t psum_in,
    input  logic           row_last,
    // MAC lanes
    mac_if.acc             lane0,
    mac_if.acc             lane1,
    // Result output
    output logic           out_valid,
    input  logic           out_ready,
    output cnv_pkg::psum_t out_psum,
    output cnv_pkg::col_t  out_col,
    output logic           out_row_end
);

    // Rightmost column, matching the real feature map position
    localparam cnv_pkg::col_t LAST_COL = cnv_pkg::col_t'(`CNV_LENROW - 1);

    // ========================================================================
    // Declarations
    // ========================================================================
    cnv_pkg::acc_state_e state_q;
    logic                start_q;
    logic                last_q;
    cnv_pkg::col_t       col_q;

    // Stored input partial sum and final result
    cnv_pkg::psum_t      psum_q;
    cnv_pkg::psum_t      out_psum_q;

    logic                in_fire;
    logic                both_valid;
    logic                take;
    logic                out_fire;

    // ========================================================================
    // Handshakes
    // ========================================================================
    // One block in flight per row
    assign in_ready   = (state_q == cnv_pkg::ACC_IDLE);
    assign in_fire    = in_valid && in_ready;

    // Take both lane results on the same edge
    assign both_valid = lane0.res_valid && lane1.res_valid;
    assign take       = (state_q == cnv_pkg::ACC_WAIT_MAC) && both_valid;

    assign out_valid  = (state_q == cnv_pkg::ACC_OUT);
    assign out_fire   = out_valid && out_ready;

    // Lane launch and result acceptance
    assign lane0.start     = start_q;
    assign lane1.start     = start_q;
    assign lane0.res_ready = take;
    assign lane1.res_ready = take;

    // ========================================================================
    // Accumulator FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cnv_pkg::ACC_IDLE;
            start_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            // Start is a single-cycle strobe after the input transfer
            start_q <= in_fire;
            case (state_q)
                cnv_pkg::ACC_IDLE: begin
                    if (in_fire) begin
                        last_q  <= row_last;
                        state_q <= cnv_pkg::ACC_WAIT_MAC;
                    end
                end
                cnv_pkg::ACC_WAIT_MAC: begin
                    if (take) begin
                        state_q <= cnv_pkg::ACC_OUT;
                    end
                end
                cnv_pkg::ACC_OUT: begin
                    // Hold result under back-pressure
                    if (out_ready) begin
                        state_q <= cnv_pkg::ACC_IDLE;
                    end
                end
                default: begin
                    state_q <= cnv_pkg::ACC_IDLE;
                end
            endcase
        end
    end

    // ========================================================================
    // Sum path
    // ========================================================================
    always_ff @(posedge clk) begin
        if (in_fire) begin
            psum_q <= psum_in;
        end
        // Lane sums sign-extended to partial sum width
        if (take) begin
            out_psum_q <= psum_q
                        + cnv_pkg::psum_t'(lane0.sum)
                        + cnv_pkg::psum_t'(lane1.sum);
        end
    end

    // ========================================================================
    // Column address
    // ========================================================================
    // Counts down from the row end, reloads on the last column of a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= LAST_COL;
        end else if (out_fire) begin
            if (last_q || (col_q == '0)) begin
                col_q <= LAST_COL;
            end else begin
                col_q <= col_q - 1'b1;
            end
        end
    end

    assign out_psum    = out_psum_q;
    assign out_col     = col_q;
    assign out_row_end = last_q;

    // ========================================================================
    // Assertions
    // ========================================================================
    a_out_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> $stable(out_psum)
    );

    a_one_in_flight : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(in_ready && out_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/sparse_mac.sv ====
/*
 * Sparse MAC lane
 * Multiplies one activation block with one weight row, visiting only the
 * positions where both flags are set, one position per cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnv_defs.svh"

module sparse_mac (
    input  logic            clk,
    input  logic            rst_n,
    input  cnv_pkg::block_t act,
    input  cnv_pkg::flag_t  act_flag,
    input  cnv_pkg::block_t wei,
    input  cnv_pkg::flag_t  wei_flag,
    mac_if.mac              port
);

    localparam int IDX_W = $clog2(`CNV_BLOCK_DEPTH);

    // ========================================================================
    // Declarations
    // ========================================================================
    cnv_pkg::mac_state_e             state_q;

    // Latched operands and remaining work mask
    cnv_pkg::block_t                 act_q;
    cnv_pkg::block_t                 wei_q;
    cnv_pkg::flag_t                  mask_q;

    cnv_pkg::flag_t                  match;
    cnv_pkg::flag_t                  mask_nxt;
    logic [IDX_W-1:0]                idx;
    logic signed [2*`CNV_DATA_W-1:0] prod;
    logic                            launch;

    cnv_pkg::mac_t                   sum_q;
    logic [`CNV_HIT_W-1:0]           hits_q;

    // Index of the lowest set bit, scanning down so low bits win
    function automatic logic [IDX_W-1:0] lowest_set(input cnv_pkg::flag_t m);
        logic [IDX_W-1:0] pos;
        pos = '0;
        for (int i = `CNV_BLOCK_DEPTH - 1; i >= 0; i--) begin
            if (m[i]) begin
                pos = IDX_W'(i);
            end
        end
        return pos;
    endfunction

    // ========================================================================
    // Position select and product
    // ========================================================================
    // Only pairs with both entries nonzero contribute
    assign match    = act_flag & wei_flag;
    assign launch   = (state_q == cnv_pkg::MAC_IDLE) && port.start;

    assign idx      = lowest_set(mask_q);
    assign prod     = $signed(act_q[idx]) * $signed(wei_q[idx]);

    // Drop the lowest set bit
    assign mask_nxt = mask_q & (mask_q - 1'b1);

    // ========================================================================
    // Lane FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cnv_pkg::MAC_IDLE;
        end else begin
            case (state_q)
                cnv_pkg::MAC_IDLE: begin
                    // Empty match goes straight to a zero result
                    if (port.start) begin
                        if (match == '0) begin
                            state_q <= cnv_pkg::MAC_DONE;
                        end else begin
                            state_q <= cnv_pkg::MAC_RUN;
                        end
                    end
                end
                cnv_pkg::MAC_RUN: begin
                    // Last matching position handled this cycle
                    if (mask_nxt == '0) begin
                        state_q <= cnv_pkg::MAC_DONE;
                    end
                end
                cnv_pkg::MAC_DONE: begin
                    if (port.res_ready) begin
                        state_q <= cnv_pkg::MAC_IDLE;
                    end
                end
                default: begin
                    state_q <= cnv_pkg::MAC_IDLE;
                end
            endcase
        end
    end

    // ========================================================================
    // Operand capture and accumulation
    // ========================================================================
    always_ff @(posedge clk) begin
        if (launch) begin
            act_q  <= act;
            wei_q  <= wei;
            mask_q <= match;
            sum_q  <= '0;
            hits_q <= '0;
        end else if (state_q == cnv_pkg::MAC_RUN) begin
            mask_q <= mask_nxt;
            sum_q  <= sum_q + cnv_pkg::mac_t'(prod);
            hits_q <= hits_q + 1'b1;
        end
    end

    // Result held in DONE until the accumulator takes it
    assign port.res_valid = (state_q == cnv_pkg::MAC_DONE);
    assign port.sum       = sum_q;
    assign port.hits      = hits_q;

    // ========================================================================
    // Assertions
    // ========================================================================
    // Accumulator must not launch a busy lane
    a_start_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        port.start |-> (state_q == cnv_pkg::MAC_IDLE)
    );

    // Result payload frozen while stalled
    a_sum_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (port.res_valid && !port.res_ready) |=> $stable(port.sum)
    );

endmodule

`default_nettype wire
